//--- logic/platform_pkg.sv
// platform package: bus request/response types, region codes and register offsets
package platform_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // bus types
    ////////////////////////////////////////////////////////////////////////////

    typedef struct packed {
        logic        en;      // single-cycle request strobe
        logic [3:0]  we;      // byte write enables, zero on a read
        logic [31:0] addr;
        logic [31:0] wdata;
    } bus_req_t;

    typedef struct packed {
        logic        valid;   // read data present this cycle
        logic [31:0] rdata;
    } bus_rsp_t;

    ////////////////////////////////////////////////////////////////////////////
    // address map, top nibble of the address
    ////////////////////////////////////////////////////////////////////////////

    localparam logic [3:0] REGION_RTC     = 4'h2;
    localparam logic [3:0] REGION_PLIC_LO = 4'h3;
    localparam logic [3:0] REGION_PLIC_HI = 4'h7;

    ////////////////////////////////////////////////////////////////////////////
    // register offsets, address bits 3:0
    ////////////////////////////////////////////////////////////////////////////

    // machine timer
    localparam logic [3:0] MTIME_LO    = 4'h0;
    localparam logic [3:0] MTIME_HI    = 4'h4;
    localparam logic [3:0] MTIMECMP_LO = 4'h8;
    localparam logic [3:0] MTIMECMP_HI = 4'hC;

    // interrupt controller
    localparam logic [3:0] IRQ_ENABLE  = 4'h0;  // read/write
    localparam logic [3:0] IRQ_PENDING = 4'h4;  // read only
    localparam logic [3:0] IRQ_CLAIM   = 4'h8;  // read clears the claimed source

    // source ids run 1..I_CNT, so 31 fills the 32-bit word
    localparam logic [4:0] I_CNT_MAX = 5'd31;

endpackage

//--- logic/mtimer.sv
// machine timer: free-running 64-bit mtime, mtimecmp and the timer interrupt
`timescale 1ns/1ps

module mtimer (
    input  logic                    clk,
    input  logic                    rst_i,
    input  platform_pkg::bus_req_t  req_i,
    output logic [31:0]             rdata_o,
    output logic                    mti_o
);

    logic [63:0] mtime;
    logic [63:0] mtimecmp;
    logic [3:0]  offset;
    logic        wr;
    logic        rd;

    // byte-wise merge of a write into one 32-bit half
    function automatic logic [31:0] merge_bytes(
        input logic [31:0] old_word,
        input logic [31:0] new_word,
        input logic [3:0]  be
    );
        logic [31:0] res;
        res = old_word;
        for (int b = 0; b < 4; b++) begin
            if (be[b]) begin
                res[8*b +: 8] = new_word[8*b +: 8];
            end
        end
        return res;
    endfunction

    assign offset = req_i.addr[3:0];
    assign wr     = req_i.en && (req_i.we != 4'h0);
    assign rd     = req_i.en && (req_i.we == 4'h0);

    ////////////////////////////////////////////////////////////////////////////
    // counter and compare registers
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst_i) begin
            mtime    <= '0;
            mtimecmp <= '1;               // max compare keeps mti low
        end else begin
            if (wr && offset == platform_pkg::MTIME_LO) begin
                mtime[31:0]  <= merge_bytes(mtime[31:0], req_i.wdata, req_i.we);
            end else if (wr && offset == platform_pkg::MTIME_HI) begin
                mtime[63:32] <= merge_bytes(mtime[63:32], req_i.wdata, req_i.we);
            end else begin
                mtime <= mtime + 64'd1;   // no increment in a write cycle
            end

            if (wr && offset == platform_pkg::MTIMECMP_LO) begin
                mtimecmp[31:0]  <= merge_bytes(mtimecmp[31:0], req_i.wdata, req_i.we);
            end
            if (wr && offset == platform_pkg::MTIMECMP_HI) begin
                mtimecmp[63:32] <= merge_bytes(mtimecmp[63:32], req_i.wdata, req_i.we);
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // read port, sampled at the request edge
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rd) begin
            case (offset)
                platform_pkg::MTIME_LO:    rdata_o <= mtime[31:0];
                platform_pkg::MTIME_HI:    rdata_o <= mtime[63:32];
                platform_pkg::MTIMECMP_LO: rdata_o <= mtimecmp[31:0];
                platform_pkg::MTIMECMP_HI: rdata_o <= mtimecmp[63:32];
                default:                   rdata_o <= 32'h0;  // hole in the map
            endcase
        end
    end

    assign mti_o = (mtime >= mtimecmp);  // unsigned 64-bit compare

endmodule

//--- logic/irq_controller.sv
// interrupt controller: sticky pending bits, enable mask, claim and external interrupt
`timescale 1ns/1ps

module irq_controller #(
    parameter int I_CNT = 4
) (
    input  logic                    clk,
    input  logic                    rst_i,
    input  platform_pkg::bus_req_t  req_i,
    input  logic [I_CNT:1]          irq_i,
    output logic [31:0]             rdata_o,
    output logic                    mei_o
);

    logic [I_CNT:1] enable;
    logic [I_CNT:1] pending;
    logic [I_CNT:1] active;        // pending and enabled
    logic [I_CNT:1] claim_mask;    // one-hot clear for the claimed source
    logic [$bits(platform_pkg::I_CNT_MAX)-1:0] claim_id;
    logic [31:0]    enable_word;
    logic [31:0]    pending_word;
    logic [3:0]     offset;
    logic           wr;
    logic           rd;
    logic           claim;

    assign offset = req_i.addr[3:0];
    assign wr     = req_i.en && (req_i.we != 4'h0);
    assign rd     = req_i.en && (req_i.we == 4'h0);
    assign claim  = rd && (offset == platform_pkg::IRQ_CLAIM);
    assign active = pending & enable;

    ////////////////////////////////////////////////////////////////////////////
    // claim selection
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        claim_id = '0;                    // 0 means nothing to claim
        for (int i = I_CNT; i >= 1; i--) begin
            if (active[i]) begin
                claim_id = ($bits(claim_id))'(i);  // lowest id wins
            end
        end
    end

    always_comb begin
        claim_mask = '0;
        for (int i = 1; i <= I_CNT; i++) begin
            claim_mask[i] = claim && (claim_id == ($bits(claim_id))'(i));
        end
    end

    // source k sits at word bit k, bit 0 stays zero
    always_comb begin
        enable_word  = '0;
        pending_word = '0;
        enable_word[I_CNT:1]  = enable;
        pending_word[I_CNT:1] = pending;
    end

    ////////////////////////////////////////////////////////////////////////////
    // state
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst_i) begin
            enable  <= '0;
            pending <= '0;
            mei_o   <= 1'b0;
        end else begin
            if (wr && offset == platform_pkg::IRQ_ENABLE) begin
                enable <= req_i.wdata[I_CNT:1];  // full-word write, be ignored
            end
            pending <= (pending & ~claim_mask) | irq_i;  // live line re-sets
            mei_o   <= |active;
        end
    end

    always_ff @(posedge clk) begin
        if (rd) begin
            case (offset)
                platform_pkg::IRQ_ENABLE:  rdata_o <= enable_word;
                platform_pkg::IRQ_PENDING: rdata_o <= pending_word;
                platform_pkg::IRQ_CLAIM:   rdata_o <= 32'(claim_id);
                default:                   rdata_o <= 32'h0;
            endcase
        end
    end

endmodule

//--- logic/bus_decode.sv
// bus decoder: region select, per-block strobes and registered read-data mux
`timescale 1ns/1ps

module bus_decode (
    input  logic                    clk,
    input  logic                    rst_i,
    input  platform_pkg::bus_req_t  req_i,
    output platform_pkg::bus_req_t  rtc_req_o,
    output platform_pkg::bus_req_t  plic_req_o,
    input  logic [31:0]             rtc_rdata_i,
    input  logic [31:0]             plic_rdata_i,
    output platform_pkg::bus_rsp_t  rsp_o
);

    logic [3:0] region;
    logic       rtc_hit;
    logic       plic_hit;
    logic       rd;
    logic       rd_q;           // read issued last cycle
    logic       rtc_sel_q;
    logic       plic_sel_q;

    assign region   = req_i.addr[31:28];
    assign rtc_hit  = (region == platform_pkg::REGION_RTC);
    assign plic_hit = (region >= platform_pkg::REGION_PLIC_LO) &&
                      (region <= platform_pkg::REGION_PLIC_HI);
    assign rd       = req_i.en && (req_i.we == 4'h0);

    ////////////////////////////////////////////////////////////////////////////
    // request steering
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        rtc_req_o     = req_i;
        plic_req_o    = req_i;
        rtc_req_o.en  = req_i.en && rtc_hit;
        plic_req_o.en = req_i.en && plic_hit;
    end

    ////////////////////////////////////////////////////////////////////////////
    // response path, one cycle after the request
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst_i) begin
            rd_q       <= 1'b0;
            rtc_sel_q  <= 1'b0;
            plic_sel_q <= 1'b0;
        end else begin
            rd_q       <= rd;
            rtc_sel_q  <= rd && rtc_hit;
            plic_sel_q <= rd && plic_hit;
        end
    end

    always_comb begin
        rsp_o.valid = rd_q;
        if (rtc_sel_q) begin
            rsp_o.rdata = rtc_rdata_i;
        end else if (plic_sel_q) begin
            rsp_o.rdata = plic_rdata_i;
        end else begin
            rsp_o.rdata = 32'h0;  // unmapped reads as zero
        end
    end

endmodule

//--- logic/sysctl_top.sv
// system control top: bus decoder, machine timer and interrupt controller
`timescale 1ns/1ps

module sysctl_top #(
    parameter int I_CNT = 4       // 1..31 external sources
) (
    input  logic                    clk,
    input  logic                    rst_i,
    input  platform_pkg::bus_req_t  req_i,
    input  logic [I_CNT:1]          irq_i,
    output platform_pkg::bus_rsp_t  rsp_o,
    output logic                    mti_o,
    output logic                    mei_o
);

    platform_pkg::bus_req_t rtc_req;
    platform_pkg::bus_req_t plic_req;
    logic [31:0]            rtc_rdata;
    logic [31:0]            plic_rdata;

    ////////////////////////////////////////////////////////////////////////////
    // decoder
    ////////////////////////////////////////////////////////////////////////////

    bus_decode bus_decode_i (
        .clk          (clk),
        .rst_i        (rst_i),
        .req_i        (req_i),
        .rtc_req_o    (rtc_req),
        .plic_req_o   (plic_req),
        .rtc_rdata_i  (rtc_rdata),
        .plic_rdata_i (plic_rdata),
        .rsp_o        (rsp_o)
    );

    ////////////////////////////////////////////////////////////////////////////
    // timer and interrupt controller
    ////////////////////////////////////////////////////////////////////////////

    mtimer mtimer_i (
        .clk     (clk),
        .rst_i   (rst_i),
        .req_i   (rtc_req),
        .rdata_o (rtc_rdata),
        .mti_o   (mti_o)
    );

    irq_controller #(
        .I_CNT (I_CNT)
    ) irq_controller_i (
        .clk     (clk),
        .rst_i   (rst_i),
        .req_i   (plic_req),
        .irq_i   (irq_i),
        .rdata_o (plic_rdata),
        .mei_o   (mei_o)
    );

endmodule

//--- tb/tb_clock.sv
// testbench clock and reset source: 40 ns clock, reset held for a fixed number of cycles
`timescale 1ns/1ps

module tb_clock #(
    parameter int RST_CYCLES = 10
) (
    output logic clk,
    output logic rst_o
);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;     // 40 ns period
    end

    initial begin
        rst_o = 1'b1;
        repeat (RST_CYCLES) @(posedge clk);
        #2;
        rst_o = 1'b0;               // same skew as the bus stimulus
    end

endmodule

//--- tb/sysctl_tb.sv
// system control testbench driving LFSR bus traffic and irq pulses against a reference model
`timescale 1ns/1ps

module sysctl_tb;

    localparam int I_CNT      = 4;
    localparam int N_TIMER    = 40;
    localparam int MTI_ROUNDS = 3;
    localparam int MTI_WAIT   = 30;
    localparam int N_IRQ      = 60;
    localparam int N_DEC      = 60;
    // reset plus upper bounds of the five groups in cycles
    localparam int RUN_CYCLES = 10 + 9 + (2 * N_TIMER + 10) + MTI_ROUNDS * (MTI_WAIT + 10)
                                + (N_IRQ + 1) + (N_DEC + 2);
    localparam logic [31:0] RTC_BASE  = 32'h2000_0000;
    localparam logic [31:0] PLIC_BASE = 32'h3000_0000;

    logic                   clk, rst, mti, mei;
    logic [I_CNT:1]         irq_drv;
    platform_pkg::bus_req_t req_drv;
    platform_pkg::bus_rsp_t rsp;
    logic [63:0]            m_mtime, m_cmp;       // model registers
    logic [I_CNT:1]         m_en, m_pend;
    platform_pkg::bus_rsp_t exp_rsp;               // response due after the next edge
    logic                   exp_mti, exp_mei;
    logic [31:0]            lfsr;
    int                     cycles = 0;

    tb_clock tb_clock_i (.clk(clk), .rst_o(rst));

    sysctl_top #(.I_CNT(I_CNT)) sysctl_top_i (
        .clk(clk), .rst_i(rst), .req_i(req_drv), .irq_i(irq_drv),
        .rsp_o(rsp), .mti_o(mti), .mei_o(mei)
    );

    ////////////////////////////////////////////////////////////////////////////
    // checks and random source
    ////////////////////////////////////////////////////////////////////////////

    task automatic stop_run();
        $display("Something failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_rsp(input platform_pkg::bus_rsp_t got,
                             input platform_pkg::bus_rsp_t exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t: rsp_o expected %h got %h", $time, exp, got);
            stop_run();
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s expected %b got %b", $time, name, exp, got);
            stop_run();
        end
    endtask

    task automatic check_quiet(input platform_pkg::bus_rsp_t got);
        if (got.valid !== 1'b0) begin
            $display("ERROR at %0t: a response came back with no read outstanding", $time);
            stop_run();
        end
    endtask

    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic draw_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            v = {v[30:0], lfsr[0]};
        end
    endtask

    function automatic logic [31:0] apply_bytes(input logic [31:0] old_w,
                                                input logic [31:0] new_w,
                                                input logic [3:0] be);
        logic [31:0] mask;
        mask = {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
        return (old_w & ~mask) | (new_w & mask);
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // reference model for one bus cycle
    ////////////////////////////////////////////////////////////////////////////

    task automatic model_step(input platform_pkg::bus_req_t req, input logic [I_CNT:1] irq);
        logic [3:0]     off;
        logic           rd, wr, is_rtc, is_plic;
        logic [I_CNT:1] tmp, clr;
        logic [31:0]    id, word;
        off     = req.addr[3:0];
        rd      = req.en && req.we == 4'h0;
        wr      = req.en && req.we != 4'h0;
        is_rtc  = req.addr[31:28] == platform_pkg::REGION_RTC;
        is_plic = req.addr[31:28] >= platform_pkg::REGION_PLIC_LO &&
                  req.addr[31:28] <= platform_pkg::REGION_PLIC_HI;
        tmp     = m_pend & m_en;
        exp_mei = |tmp;                             // one edge behind
        id      = 32'd0;
        for (int i = 1; i <= I_CNT; i++) begin
            if (tmp[1] && id == 32'd0) id = i;      // lowest id first
            tmp = tmp >> 1;
        end
        word = 32'h0;
        if (rd && is_rtc) begin
            case (off)
                platform_pkg::MTIME_LO:    word = m_mtime[31:0];
                platform_pkg::MTIME_HI:    word = m_mtime[63:32];
                platform_pkg::MTIMECMP_LO: word = m_cmp[31:0];
                platform_pkg::MTIMECMP_HI: word = m_cmp[63:32];
                default:                   word = 32'h0;
            endcase
        end
        if (rd && is_plic) begin
            case (off)
                platform_pkg::IRQ_ENABLE:  word = 32'({m_en, 1'b0});
                platform_pkg::IRQ_PENDING: word = 32'({m_pend, 1'b0});
                platform_pkg::IRQ_CLAIM:   word = id;
                default:                   word = 32'h0;
            endcase
        end
        if (wr && is_rtc && off == platform_pkg::MTIME_LO)
            m_mtime[31:0] = apply_bytes(m_mtime[31:0], req.wdata, req.we);
        else if (wr && is_rtc && off == platform_pkg::MTIME_HI)
            m_mtime[63:32] = apply_bytes(m_mtime[63:32], req.wdata, req.we);
        else
            m_mtime = m_mtime + 64'd1;
        if (wr && is_rtc && off == platform_pkg::MTIMECMP_LO)
            m_cmp[31:0] = apply_bytes(m_cmp[31:0], req.wdata, req.we);
        if (wr && is_rtc && off == platform_pkg::MTIMECMP_HI)
            m_cmp[63:32] = apply_bytes(m_cmp[63:32], req.wdata, req.we);
        if (wr && is_plic && off == platform_pkg::IRQ_ENABLE)
            m_en = req.wdata[I_CNT:1];
        clr = '0;
        if (rd && is_plic && off == platform_pkg::IRQ_CLAIM && id != 32'd0) begin
            clr[1] = 1'b1;
            clr = clr << (id - 32'd1);
        end
        m_pend        = (m_pend & ~clr) | irq;     // a live line sets its bit again
        exp_rsp.valid = rd;
        exp_rsp.rdata = word;
        exp_mti       = m_mtime >= m_cmp;
    endtask

    // drive one cycle at the skew point and check the outputs after the edge
    task automatic bus_cycle(input platform_pkg::bus_req_t req, input logic [I_CNT:1] irq);
        req_drv = req;
        irq_drv = irq;
        model_step(req, irq);
        @(posedge clk);
        #2;
        if (exp_rsp.valid) check_rsp(rsp, exp_rsp);
        else check_quiet(rsp);
        check_bit("mti_o", mti, exp_mti);
        check_bit("mei_o", mei, exp_mei);
    endtask

    task automatic access(input logic [31:0] addr, input logic [3:0] we, input logic [31:0] data);
        platform_pkg::bus_req_t r;
        r.en    = 1'b1;
        r.we    = we;
        r.addr  = addr;
        r.wdata = data;
        bus_cycle(r, '0);
    endtask

    task automatic idle(input int n);
        for (int i = 0; i < n; i++) bus_cycle('0, '0);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        logic [31:0]            a, b, c, d;
        platform_pkg::bus_req_t r;
        req_drv = '0;
        irq_drv = '0;
        lfsr    = 32'd93152;
        m_mtime = '0;
        m_cmp   = '1;
        m_en    = '0;
        m_pend  = '0;
        exp_rsp = '0;
        exp_mti = 1'b0;
        exp_mei = 1'b0;
        @(negedge rst);
        check_bit("mti_o", mti, 1'b0);
        check_bit("mei_o", mei, 1'b0);
        check_quiet(rsp);
        draw_bits(3, a);
        idle(int'(a[2:0]));
        access(RTC_BASE | 32'(platform_pkg::MTIME_LO), 4'h0, 32'h0);  // cycles since reset

        // timer carry into the high half followed by random byte writes and reads
        access(RTC_BASE | 32'(platform_pkg::MTIME_LO), 4'hF, 32'hFFFF_FFFD);
        access(RTC_BASE | 32'(platform_pkg::MTIME_HI), 4'h0, 32'h0);
        access(RTC_BASE | 32'(platform_pkg::MTIME_LO), 4'h0, 32'h0);
        idle(4);
        access(RTC_BASE | 32'(platform_pkg::MTIME_HI), 4'h0, 32'h0);
        access(RTC_BASE | 32'(platform_pkg::MTIME_LO), 4'h0, 32'h0);
        for (int n = 0; n < N_TIMER; n++) begin
            draw_bits(2, a);
            draw_bits(4, b);
            draw_bits(32, c);
            draw_bits(2, d);
            access(RTC_BASE | {28'h0, a[1:0], 2'b00}, b[3:0], c);   // be of 0 is a read
            access(RTC_BASE | {28'h0, d[1:0], 2'b00}, 4'h0, 32'h0);
        end

        // timer interrupt with the compare a few cycles ahead and then pushed away
        for (int n = 0; n < MTI_ROUNDS; n++) begin
            access(RTC_BASE | 32'(platform_pkg::MTIMECMP_HI), 4'hF, 32'hFFFF_FFFF);
            access(RTC_BASE | 32'(platform_pkg::MTIME_HI), 4'hF, 32'h0);
            access(RTC_BASE | 32'(platform_pkg::MTIME_LO), 4'hF, 32'h0);
            draw_bits(4, a);
            access(RTC_BASE | 32'(platform_pkg::MTIMECMP_LO), 4'hF, m_mtime[31:0] + 32'd8 + a);
            access(RTC_BASE | 32'(platform_pkg::MTIMECMP_HI), 4'hF, 32'h0);
            idle(MTI_WAIT);
            access(RTC_BASE | 32'(platform_pkg::MTIMECMP_LO), 4'hF, m_mtime[31:0] + 32'd1000);
            idle(2);
        end

        // interrupt controller with random pulses, pending reads, claims and mask changes
        draw_bits(32, a);
        access(PLIC_BASE | 32'(platform_pkg::IRQ_ENABLE), 4'h1, a);
        for (int n = 0; n < N_IRQ; n++) begin
            draw_bits(I_CNT, a);
            draw_bits(I_CNT, b);
            draw_bits(2, c);
            draw_bits(32, d);
            r.en    = c[1:0] != 2'd0;
            r.we    = c[1:0] == 2'd3 ? d[3:0] | 4'h1 : 4'h0;
            r.addr  = PLIC_BASE | {28'h0, (c[1:0] == 2'd3 ? 2'd0 : c[1:0]), 2'b00};  // 1 pending, 2 claim, 3 mask
            r.wdata = d;
            bus_cycle(r, a[I_CNT-1:0] & b[I_CNT-1:0]);     // quarter-rate pulses
        end

        // back-to-back decoding traffic over the whole map
        for (int n = 0; n < N_DEC; n++) begin
            draw_bits(4, a);
            draw_bits(2, b);
            draw_bits(2, c);
            draw_bits(32, d);
            access({a[3:0], 24'h0, b[1:0], 2'b00}, c[1:0] == 2'd3 ? 4'hF : 4'h0, d);
        end
        idle(2);
        $display("Everything OK");
        $finish;
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > 4 * RUN_CYCLES) begin
            $display("ERROR: the run did not finish within %0d cycles", 4 * RUN_CYCLES);
            stop_run();
        end
    end

endmodule

//--- Makefile
# Verilator simulation of the system control slice
VERILATOR ?= verilator
TOP       ?= sysctl_tb
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing
PASS_MSG  ?= Everything OK

.PHONY: sim clean

# builds, runs and fails unless the pass line shows up
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- src.f
logic/platform_pkg.sv
logic/mtimer.sv
logic/irq_controller.sv
logic/bus_decode.sv
logic/sysctl_top.sv
tb/tb_clock.sv
tb/sysctl_tb.sv
